// ==== flist.f ====
design/serdes_pkg.sv
design/tx_credit_queue.sv
design/lane_serializer.sv
design/lane_deserializer.sv
design/rx_credit_buffer.sv
design/serdes_loopback_top.sv
bench/serdes_loopback_tb.sv

// ==== Bender.yml ====
package:
  name: serdes_loopback

sources:
  - files:
      - design/serdes_pkg.sv
      - design/tx_credit_queue.sv
      - design/lane_serializer.sv
      - design/lane_deserializer.sv
      - design/rx_credit_buffer.sv
      - design/serdes_loopback_top.sv
  - target: test
    files:
      - bench/serdes_loopback_tb.sv

// ==== bench/serdes_loopback_tb.sv ====
`timescale 1ns/100ps

module serdes_loopback_tb import serdes_pkg::*;;

    localparam int DW         = DATA_WIDTH_DEF;
    localparam int TX_DEPTH   = TX_DEPTH_DEF;
    localparam int RX_DEPTH   = RX_DEPTH_DEF;
    localparam int LINE_DELAY = LINE_DELAY_DEF;
    localparam int TIMEOUT    = 64;

    logic          CLKDIV = 1'b0;
    logic          SYSCLK = 1'b1;
    logic          RST;
    logic          in_valid;
    logic [DW-1:0] in_data;
    logic          out_credit;
    logic          in_credit;
    logic          out_valid;
    logic [DW-1:0] out_data;
    logic          link_up;

    // Scoreboard and host-side bookkeeping
    logic [DW-1:0] exp_q[$];
    logic [DW-1:0] exp_word;
    integer        seed;
    int            errors;
    int            host_credits;
    int            in_credit_cnt;
    int            out_cnt;
    int            sent_total;
    int            credits_granted;

    // SYSCLK rises on every CLKDIV rising edge
    always #20 CLKDIV = ~CLKDIV;
    always #2.5 SYSCLK = ~SYSCLK;

    serdes_loopback_top #(
        .DATA_WIDTH (DW),
        .TX_DEPTH   (TX_DEPTH),
        .RX_DEPTH   (RX_DEPTH),
        .LINE_DELAY (LINE_DELAY)
    ) serdes_loopback_top_inst (
        .SYSCLK     (SYSCLK),
        .CLKDIV     (CLKDIV),
        .RST        (RST),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .link_up    (link_up)
    );

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string msg);
        $display("Timeout: %s", msg);
        errors++;
    endtask

    // Outputs are sampled half a cycle after they change
    always @(negedge CLKDIV) begin
        if (!RST) begin
            if (in_credit) begin
                in_credit_cnt++;
                host_credits++;
            end
            if (out_valid) begin
                out_cnt++;
                assert (exp_q.size() != 0) else
                    report_mismatch("out_valid with no word outstanding");
                if (exp_q.size() != 0) begin
                    exp_word = exp_q.pop_front();
                    assert (out_data == exp_word) else
                        report_mismatch($sformatf("out_data %h, expected %h", out_data, exp_word));
                end
            end
        end
    end

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge CLKDIV);
    endtask

    // Caller sits on a falling edge and holds a host credit
    task automatic drive_word(input logic [DW-1:0] w);
        in_valid = 1'b1;
        in_data  = w;
        host_credits--;
        exp_q.push_back(w);
        sent_total++;
    endtask

    task automatic send_word(input logic [DW-1:0] w);
        int n;
        n = 0;
        while (host_credits == 0 && n < TIMEOUT) begin
            @(negedge CLKDIV);
            n++;
        end
        if (host_credits == 0) begin
            report_timeout("no host credit came back for the next word");
        end else begin
            drive_word(w);
            @(negedge CLKDIV);
            in_valid = 1'b0;
        end
    endtask

    task automatic grant_credit();
        out_credit = 1'b1;
        credits_granted++;
        @(negedge CLKDIV);
        out_credit = 1'b0;
    endtask

    task automatic wait_outputs(input int out_target, input int cred_target, input int limit);
        int n;
        n = 0;
        while ((out_cnt < out_target || in_credit_cnt < cred_target) && n < limit) begin
            @(negedge CLKDIV);
            n++;
        end
        if (out_cnt < out_target || in_credit_cnt < cred_target) begin
            report_timeout($sformatf("%0d of %0d words and %0d of %0d credits after %0d cycles",
                out_cnt, out_target, in_credit_cnt, cred_target, limit));
        end
    endtask

    task automatic reset_test();
        int n;
        repeat (8) begin
            @(negedge CLKDIV);
            assert (!in_credit && !out_valid && !link_up) else
                report_mismatch("in_credit, out_valid or link_up high during reset");
        end
        RST = 1'b0;
        host_credits = TX_DEPTH;
        n = 0;
        while (!link_up && n < TIMEOUT) begin
            @(negedge CLKDIV);
            n++;
        end
        if (!link_up) begin
            report_timeout("link_up did not rise within 64 cycles after reset");
        end
    endtask

    task automatic single_word_test();
        int out_start;
        int cred_start;
        out_start  = out_cnt;
        cred_start = in_credit_cnt;
        send_word(DW'($random(seed)));
        grant_credit();
        wait_outputs(out_start + 1, cred_start + 1, TIMEOUT);
        idle(4);
        assert (out_cnt == out_start + 1) else
            report_mismatch("single word gave wrong out_valid count");
        assert (in_credit_cnt == cred_start + 1) else
            report_mismatch("single word gave wrong in_credit count");
    endtask

    task automatic burst_test();
        int out_start;
        out_start = out_cnt;
        repeat (TX_DEPTH) grant_credit();
        repeat (TX_DEPTH) send_word(DW'($random(seed)));
        wait_outputs(out_start + TX_DEPTH, 0, 4 * TIMEOUT);
        idle(16);
        assert (out_cnt == out_start + TX_DEPTH) else
            report_mismatch("burst gave extra out_valid");
        assert (exp_q.size() == 0) else report_mismatch("burst words still outstanding");
    endtask

    task automatic backpressure_test();
        int sent;
        int out_start;
        sent      = 0;
        out_start = out_cnt;
        // Keep sending as long as credits come back
        repeat (48) begin
            if (host_credits > 0) begin
                drive_word(DW'($random(seed)));
                sent++;
            end else begin
                in_valid = 1'b0;
            end
            @(negedge CLKDIV);
        end
        in_valid = 1'b0;
        assert (out_cnt == out_start) else report_mismatch("out_valid without out_credit");
        assert (sent <= TX_DEPTH + RX_DEPTH) else
            report_mismatch($sformatf("%0d words accepted under back-pressure", sent));
        repeat (sent) begin
            out_start = out_cnt;
            grant_credit();
            wait_outputs(out_start + 1, 0, TIMEOUT);
            idle(4);
            assert (out_cnt == out_start + 1) else
                report_mismatch("one credit did not give one word");
        end
        assert (exp_q.size() == 0) else report_mismatch("words lost under back-pressure");
    endtask

    task automatic accounting_test();
        wait_outputs(0, sent_total, TIMEOUT);
        assert (in_credit_cnt == sent_total) else
            report_mismatch($sformatf("%0d in_credit pulses for %0d words",
                in_credit_cnt, sent_total));
        assert (out_cnt == credits_granted) else
            report_mismatch($sformatf("%0d out_valid for %0d credits", out_cnt, credits_granted));
    endtask

    initial begin
        RST             = 1'b1;
        in_valid        = 1'b0;
        in_data         = '0;
        out_credit      = 1'b0;
        seed            = 32'h8c7cef04;
        errors          = 0;
        host_credits    = 0;
        in_credit_cnt   = 0;
        out_cnt         = 0;
        sent_total      = 0;
        credits_granted = 0;
        reset_test();
        single_word_test();
        burst_test();
        backpressure_test();
        accounting_test();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== design/serdes_loopback_top.sv ====
`timescale 1ns/100ps

module serdes_loopback_top import serdes_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int TX_DEPTH   = TX_DEPTH_DEF,
    parameter int RX_DEPTH   = RX_DEPTH_DEF,
    parameter int LINE_DELAY = LINE_DELAY_DEF
) (
    input  logic                  SYSCLK,
    input  logic                  CLKDIV,
    input  logic                  RST,
    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    input  logic                  out_credit,
    output logic                  in_credit,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  link_up
);

    logic [DATA_WIDTH-1:0] tx_word;
    logic                  tx_word_valid;
    logic                  ser_data;
    logic                  ser_valid;
    logic [DATA_WIDTH-1:0] rx_word;
    logic                  rx_word_valid;
    logic                  link_credit;

    tx_credit_queue #(
        .DATA_WIDTH (DATA_WIDTH),
        .TX_DEPTH   (TX_DEPTH),
        .RX_DEPTH   (RX_DEPTH)
    ) tx_credit_queue_inst (
        .CLKDIV        (CLKDIV),
        .RST           (RST),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .in_credit     (in_credit),
        .link_up       (link_up),
        .link_credit   (link_credit),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid)
    );

    // Serial lane, looped straight back
    lane_serializer #(
        .DATA_WIDTH (DATA_WIDTH),
        .LINE_DELAY (LINE_DELAY)
    ) lane_serializer_inst (
        .SYSCLK        (SYSCLK),
        .CLKDIV        (CLKDIV),
        .RST           (RST),
        .tx_word       (tx_word),
        .tx_word_valid (tx_word_valid),
        .ser_data      (ser_data),
        .ser_valid     (ser_valid)
    );

    lane_deserializer #(
        .DATA_WIDTH (DATA_WIDTH)
    ) lane_deserializer_inst (
        .SYSCLK        (SYSCLK),
        .CLKDIV        (CLKDIV),
        .RST           (RST),
        .ser_data      (ser_data),
        .ser_valid     (ser_valid),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .link_up       (link_up)
    );

    rx_credit_buffer #(
        .DATA_WIDTH (DATA_WIDTH),
        .RX_DEPTH   (RX_DEPTH)
    ) rx_credit_buffer_inst (
        .CLKDIV        (CLKDIV),
        .RST           (RST),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .out_credit    (out_credit),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .link_credit   (link_credit)
    );

endmodule

// ==== design/rx_credit_buffer.sv ====
`timescale 1ns/100ps

module rx_credit_buffer import serdes_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int RX_DEPTH   = RX_DEPTH_DEF
) (
    input  logic                  CLKDIV,
    input  logic                  RST,
    input  logic [DATA_WIDTH-1:0] rx_word,
    input  logic                  rx_word_valid,
    input  logic                  out_credit,
    output logic                  out_valid,
    output logic [DATA_WIDTH-1:0] out_data,
    output logic                  link_credit
);

    localparam int AW  = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CW  = $clog2(RX_DEPTH + 1);
    localparam int HCW = 16;
    localparam logic [AW-1:0] LAST = AW'(RX_DEPTH - 1);
    localparam logic [CW-1:0] FULL = CW'(RX_DEPTH);

    logic [DATA_WIDTH-1:0] mem [RX_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [HCW-1:0] host_cnt;
    logic push;
    logic pop;

    // Link credits keep incoming words within the buffer depth
    assign push = rx_word_valid && (count != FULL);
    assign pop  = (host_cnt != '0) && (count != '0);

    always_ff @(posedge CLKDIV) begin
        if (push) begin
            mem[wr_ptr] <= rx_word;
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            host_cnt    <= '0;
            out_valid   <= 1'b0;
            link_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Host grants in, deliveries out
            case ({out_credit, pop})
                2'b10:   host_cnt <= host_cnt + 1'b1;
                2'b01:   host_cnt <= host_cnt - 1'b1;
                default: host_cnt <= host_cnt;
            endcase
            out_valid   <= pop;
            link_credit <= pop;
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

endmodule

// ==== design/lane_deserializer.sv ====
`timescale 1ns/100ps

module lane_deserializer import serdes_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF
) (
    input  logic                  SYSCLK,
    input  logic                  CLKDIV,
    input  logic                  RST,
    input  logic                  ser_data,
    input  logic                  ser_valid,
    output logic [DATA_WIDTH-1:0] rx_word,
    output logic                  rx_word_valid,
    output logic                  link_up
);

    localparam int WW = 2 * DATA_WIDTH;
    localparam int OW = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam int MW = $clog2(LOCK_COUNT + 1);
    localparam logic [OW-1:0] LAST_OFF = OW'(DATA_WIDTH - 1);
    localparam logic [MW-1:0] LOCK_LAST = MW'(LOCK_COUNT - 1);
    localparam logic [DATA_WIDTH-1:0] TRAIN_W = DATA_WIDTH'(TRAIN_WORD);

    logic [WW-1:0] win_data;
    logic [WW-1:0] win_valid;
    logic [WW-1:0] samp_data;
    logic [WW-1:0] samp_valid;
    logic [OW-1:0] offset;
    logic [MW-1:0] match_cnt;
    logic [DATA_WIDTH-1:0] cur_word;
    logic [DATA_WIDTH-1:0] cur_valid;

    // Newest bit enters at the top so LSB-first frames read upward
    always_ff @(posedge SYSCLK) begin
        if (RST) begin
            win_data  <= '0;
            win_valid <= '0;
        end else begin
            win_data  <= {ser_data, win_data[WW-1:1]};
            win_valid <= {ser_valid, win_valid[WW-1:1]};
        end
    end

    // Two frames of history, so every bit phase holds one whole frame
    always_ff @(posedge CLKDIV) begin
        samp_data  <= win_data;
        samp_valid <= win_valid;
    end

    assign cur_word  = samp_data[offset +: DATA_WIDTH];
    assign cur_valid = samp_valid[offset +: DATA_WIDTH];

    // Word alignment
    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            offset        <= '0;
            match_cnt     <= '0;
            link_up       <= 1'b0;
            rx_word_valid <= 1'b0;
        end else if (!link_up) begin
            rx_word_valid <= 1'b0;
            if (cur_word == TRAIN_W) begin
                if (match_cnt == LOCK_LAST) begin
                    link_up <= 1'b1;
                end else begin
                    match_cnt <= match_cnt + 1'b1;
                end
            end else begin
                // Slip one bit and start counting again
                match_cnt <= '0;
                offset    <= (offset == LAST_OFF) ? '0 : offset + 1'b1;
            end
        end else begin
            // Offset frozen once locked
            rx_word_valid <= &cur_valid;
        end
    end

    always_ff @(posedge CLKDIV) begin
        rx_word <= cur_word;
    end

endmodule

// ==== design/lane_serializer.sv ====
`timescale 1ns/100ps

module lane_serializer import serdes_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int LINE_DELAY = LINE_DELAY_DEF
) (
    input  logic                  SYSCLK,
    input  logic                  CLKDIV,
    input  logic                  RST,
    input  logic [DATA_WIDTH-1:0] tx_word,
    input  logic                  tx_word_valid,
    output logic                  ser_data,
    output logic                  ser_valid
);

    localparam int PW = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam logic [PW-1:0] LAST_BIT = PW'(DATA_WIDTH - 1);

    logic [3:0] rst_sr;
    logic rst_lane;
    logic [DATA_WIDTH-1:0] frame_word;
    logic frame_valid;
    logic [PW-1:0] bit_cnt;
    logic [DATA_WIDTH-1:0] shift_data;
    logic shift_valid;
    logic [LINE_DELAY-1:0] dly_data;
    logic [LINE_DELAY-1:0] dly_valid;

    // Lane reset stretched past the release of RST
    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            rst_sr <= 4'hF;
        end else begin
            rst_sr <= {1'b0, rst_sr[3:1]};
        end
    end

    assign rst_lane = rst_sr[0];

    // One frame per CLKDIV, zeros while the lane is held
    always_ff @(posedge CLKDIV) begin
        if (rst_lane) begin
            frame_word  <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_word  <= tx_word;
            frame_valid <= tx_word_valid;
        end
    end

    // Bit counter wraps on the SYSCLK edge shared with CLKDIV
    always_ff @(posedge SYSCLK) begin
        if (rst_lane) begin
            bit_cnt     <= '0;
            shift_data  <= '0;
            shift_valid <= 1'b0;
        end else begin
            bit_cnt <= (bit_cnt == LAST_BIT) ? '0 : bit_cnt + 1'b1;
            if (bit_cnt == LAST_BIT) begin
                shift_data  <= frame_word;
                shift_valid <= frame_valid;
            end else begin
                // LSB first, valid flag simply repeats
                shift_data <= shift_data >> 1;
            end
        end
    end

    // Fixed delay standing in for the wire and input delay
    always_ff @(posedge SYSCLK) begin
        if (rst_lane) begin
            dly_data  <= '0;
            dly_valid <= '0;
        end else begin
            dly_data[0]  <= shift_data[0];
            dly_valid[0] <= shift_valid;
            for (int i = 1; i < LINE_DELAY; i++) begin
                dly_data[i]  <= dly_data[i-1];
                dly_valid[i] <= dly_valid[i-1];
            end
        end
    end

    assign ser_data  = dly_data[LINE_DELAY-1];
    assign ser_valid = dly_valid[LINE_DELAY-1];

endmodule

// ==== design/tx_credit_queue.sv ====
`timescale 1ns/100ps

module tx_credit_queue import serdes_pkg::*; #(
    parameter int DATA_WIDTH = DATA_WIDTH_DEF,
    parameter int TX_DEPTH   = TX_DEPTH_DEF,
    parameter int RX_DEPTH   = RX_DEPTH_DEF
) (
    input  logic                  CLKDIV,
    input  logic                  RST,
    input  logic                  in_valid,
    input  logic [DATA_WIDTH-1:0] in_data,
    output logic                  in_credit,
    input  logic                  link_up,
    input  logic                  link_credit,
    output logic [DATA_WIDTH-1:0] tx_word,
    output logic                  tx_word_valid
);

    localparam int AW = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;
    localparam int CW = $clog2(TX_DEPTH + 1);
    localparam int LW = $clog2(RX_DEPTH + 1);
    localparam logic [AW-1:0] LAST = AW'(TX_DEPTH - 1);
    localparam logic [CW-1:0] FULL = CW'(TX_DEPTH);
    localparam logic [LW-1:0] LINK_INIT = LW'(RX_DEPTH);
    localparam logic [DATA_WIDTH-1:0] TRAIN_W = DATA_WIDTH'(TRAIN_WORD);

    logic [DATA_WIDTH-1:0] mem [TX_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [LW-1:0] link_cnt;
    logic push;
    logic pop;

    // Host holds a credit for every word it sends
    assign push = in_valid && (count != FULL);
    // Launch only into a locked link with room at the far end
    assign pop  = link_up && (link_cnt != '0) && (count != '0);

    always_ff @(posedge CLKDIV) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge CLKDIV) begin
        if (RST) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            link_cnt      <= LINK_INIT;
            in_credit     <= 1'b0;
            tx_word_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Spent on launch, returned by the receive buffer
            case ({pop, link_credit})
                2'b10:   link_cnt <= link_cnt - 1'b1;
                2'b01:   link_cnt <= link_cnt + 1'b1;
                default: link_cnt <= link_cnt;
            endcase
            in_credit     <= pop;
            tx_word_valid <= pop;
        end
    end

    // Training word fills every frame without data
    always_ff @(posedge CLKDIV) begin
        tx_word <= pop ? mem[rd_ptr] : TRAIN_W;
    end

endmodule

// ==== design/serdes_pkg.sv ====
package serdes_pkg;

    // Default link geometry, overridden from the top level
    localparam int DATA_WIDTH_DEF = 8;
    localparam int TX_DEPTH_DEF   = 4;
    localparam int RX_DEPTH_DEF   = 4;

    // SYSCLK bit periods between serializer and deserializer
    localparam int LINE_DELAY_DEF = 3;

    // Idle and training pattern
    // No rotation of it equals itself, so only one window offset can match
    localparam logic [7:0] TRAIN_WORD = 8'hA5;

    // Consecutive matching training words before link_up
    localparam int LOCK_COUNT = 4;

endpackage
